//--- Makefile
# Verilator build and run for the Ethernet protocol switch

VERILATOR ?= verilator
TB_TOP    ?= eth_proto_switch_tb
RTL_TOP   ?= eth_proto_switch
FILELIST  ?= eth_proto_switch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

PASS_MSG  := Simulation finished: PASS
SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/eth_proto_switch_tb.sv
`timescale 1ns/100ps

module eth_proto_switch_tb;

    localparam int FRAME_COUNT = 12;
    localparam logic DIR_RX = 1'b0;
    localparam logic DIR_TX = 1'b1;

    // One frame of stimulus, payload derived from the seed
    typedef struct packed {
        logic                        dir;
        int                          port;
        eth_switch_pkg::ether_type_t etype;
        int                          beats;
        logic [7:0]                  seed;
    } frame_rec_t;

    // dir, tx source port, EtherType, beat count, seed
    localparam frame_rec_t FRAMES [FRAME_COUNT] = '{
        '{DIR_RX, 0, 16'h0800, 3, 8'h10},
        '{DIR_RX, 0, 16'h0806, 2, 8'h20},
        '{DIR_RX, 0, 16'h86dd, 4, 8'h30},
        '{DIR_RX, 0, 16'h0800, 1, 8'h40},
        '{DIR_TX, eth_switch_pkg::PROTO_ARP, 16'h0806, 2, 8'h50},
        '{DIR_TX, eth_switch_pkg::PROTO_IP, 16'h0800, 3, 8'h60},
        '{DIR_TX, eth_switch_pkg::PROTO_IP, 16'h0800, 2, 8'h70},
        '{DIR_TX, eth_switch_pkg::PROTO_ARP, 16'h0806, 1, 8'h80},
        '{DIR_RX, 0, 16'h0806, 3, 8'h90},
        '{DIR_RX, 0, 16'h88cc, 1, 8'ha0},
        '{DIR_RX, 0, 16'h0800, 5, 8'hb0},
        '{DIR_TX, eth_switch_pkg::PROTO_IP, 16'h0800, 4, 8'hc0}
    };

    logic                       clk;
    logic                       rst;
    logic                       s_hdr_valid;
    logic                       s_hdr_ready;
    eth_switch_pkg::eth_hdr_t   s_hdr;
    logic                       s_beat_valid;
    logic                       s_beat_ready;
    eth_switch_pkg::eth_beat_t  s_beat;
    logic                       m_hdr_valid;
    logic                       m_hdr_ready = 1'b0;
    eth_switch_pkg::eth_hdr_t   m_hdr;
    logic                       m_beat_valid;
    logic                       m_beat_ready = 1'b0;
    eth_switch_pkg::eth_beat_t  m_beat;
    eth_switch_pkg::proto_sel_t rx_hdr_valid;
    eth_switch_pkg::proto_sel_t rx_hdr_ready = '0;
    eth_switch_pkg::eth_hdr_t   rx_hdr;
    eth_switch_pkg::proto_sel_t rx_beat_valid;
    eth_switch_pkg::proto_sel_t rx_beat_ready = '0;
    eth_switch_pkg::eth_beat_t  rx_beat;
    eth_switch_pkg::proto_sel_t tx_hdr_valid;
    eth_switch_pkg::proto_sel_t tx_hdr_ready;
    eth_switch_pkg::eth_hdr_t   tx_hdr [eth_switch_pkg::PROTO_COUNT];
    eth_switch_pkg::proto_sel_t tx_beat_valid;
    eth_switch_pkg::proto_sel_t tx_beat_ready;
    eth_switch_pkg::eth_beat_t  tx_beat [eth_switch_pkg::PROTO_COUNT];

    // Scoreboards hold table indices in arrival order
    int   exp_rx_q [eth_switch_pkg::PROTO_COUNT][$];
    int   exp_tx_q [eth_switch_pkg::PROTO_COUNT][$];
    logic rx_open [eth_switch_pkg::PROTO_COUNT] = '{1'b0, 1'b0};
    int   rx_bidx [eth_switch_pkg::PROTO_COUNT] = '{0, 0};
    int   tx_src = -1;
    int   tx_bidx = 0;

    logic [31:0] lfsr_state = 32'h3c9ccee0;
    int hdr_errors = 0;
    int beat_errors = 0;
    int flag_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    int timeout_cycles = 0;

    eth_proto_switch DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic eth_switch_pkg::eth_hdr_t make_hdr(frame_rec_t r);
        eth_switch_pkg::eth_hdr_t h;
        h.dest_mac = {40'h02_00_5e_10_00, r.seed};
        h.src_mac  = {40'h02_00_00_00_aa, ~r.seed};
        h.eth_type = r.etype;
        return h;
    endfunction

    function automatic eth_switch_pkg::eth_beat_t make_beat(frame_rec_t r, int idx);
        eth_switch_pkg::eth_beat_t b;
        logic last;
        last = (idx == r.beats - 1);
        for (int k = 0; k < eth_switch_pkg::DATA_BYTES; k++) begin
            b.tdata[8*k +: 8] = r.seed + 8'(idx * 8 + k);
        end
        // Short last beat, length set by the seed
        b.tkeep = last ? (8'hff >> r.seed[6:4]) : 8'hff;
        b.tlast = last;
        b.tuser = last & r.seed[4];
        return b;
    endfunction

    task automatic check_hdr(string what, eth_switch_pkg::eth_hdr_t got,
                             eth_switch_pkg::eth_hdr_t exp);
        if (got !== exp) begin
            hdr_errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_beat(string what, eth_switch_pkg::eth_beat_t got,
                              eth_switch_pkg::eth_beat_t exp);
        if (got !== exp) begin
            beat_errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sel(string what, eth_switch_pkg::proto_sel_t got,
                             eth_switch_pkg::proto_sel_t exp);
        if (got !== exp) begin
            flag_errors++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic send_rx(int idx);
        s_hdr       <= make_hdr(FRAMES[idx]);
        s_hdr_valid <= 1'b1;
        @(posedge clk);
        while (!s_hdr_ready) @(posedge clk);
        s_hdr_valid <= 1'b0;
        for (int i = 0; i < FRAMES[idx].beats; i++) begin
            s_beat       <= make_beat(FRAMES[idx], i);
            s_beat_valid <= 1'b1;
            @(posedge clk);
            while (!s_beat_ready) @(posedge clk);
        end
        s_beat_valid <= 1'b0;
    endtask

    task automatic send_tx(int p, int idx);
        tx_hdr[p]       <= make_hdr(FRAMES[idx]);
        tx_hdr_valid[p] <= 1'b1;
        @(posedge clk);
        while (!tx_hdr_ready[p]) @(posedge clk);
        tx_hdr_valid[p] <= 1'b0;
        for (int i = 0; i < FRAMES[idx].beats; i++) begin
            tx_beat[p]       <= make_beat(FRAMES[idx], i);
            tx_beat_valid[p] <= 1'b1;
            @(posedge clk);
            while (!tx_beat_ready[p]) @(posedge clk);
        end
        tx_beat_valid[p] <= 1'b0;
    endtask

    task automatic drive_rx_frames();
        for (int i = 0; i < FRAME_COUNT; i++) begin
            if (FRAMES[i].dir == DIR_RX) begin
                send_rx(i);
            end
        end
    endtask

    task automatic drive_tx_frames(int p);
        for (int i = 0; i < FRAME_COUNT; i++) begin
            if (FRAMES[i].dir == DIR_TX && FRAMES[i].port == p) begin
                send_tx(p, i);
            end
        end
    endtask

    function automatic int pending_frames();
        int n;
        n = 0;
        for (int p = 0; p < eth_switch_pkg::PROTO_COUNT; p++) begin
            n += exp_rx_q[p].size() + exp_tx_q[p].size();
        end
        return n;
    endfunction

    function automatic int count_missing();
        int n;
        n = 0;
        for (int p = 0; p < eth_switch_pkg::PROTO_COUNT; p++) begin
            for (int i = 0; i < exp_rx_q[p].size(); i++) begin
                $display("Frame %0d never arrived on rx port %0d", exp_rx_q[p][i], p);
                n++;
            end
            for (int i = 0; i < exp_tx_q[p].size(); i++) begin
                $display("Frame %0d from tx port %0d never left on m", exp_tx_q[p][i], p);
                n++;
            end
        end
        return n;
    endfunction

    task automatic print_counts(int missing);
        $display("Errors: header %0d, beat %0d, flag %0d, other %0d, missing frames %0d",
                 hdr_errors, beat_errors, flag_errors, other_errors, missing);
    endtask

    // Random back-pressure on every ready
    always @(posedge clk) begin
        for (int p = 0; p < eth_switch_pkg::PROTO_COUNT; p++) begin
            rx_hdr_ready[p]  <= rand_bit();
            rx_beat_ready[p] <= rand_bit();
        end
        m_hdr_ready  <= rand_bit();
        m_beat_ready <= rand_bit();
    end

    always @(posedge clk) begin
        if (!rst) begin
            for (int p = 0; p < eth_switch_pkg::PROTO_COUNT; p++) begin
                if (rx_hdr_valid[p] && rx_hdr_ready[p]) begin
                    if (exp_rx_q[p].size() == 0) begin
                        other_errors++;
                        $display("Unexpected frame header on rx port %0d at %0t", p, $time);
                    end else begin
                        check_hdr("rx header", rx_hdr, make_hdr(FRAMES[exp_rx_q[p][0]]));
                        rx_open[p] = 1'b1;
                        rx_bidx[p] = 0;
                    end
                end
                if (rx_beat_valid[p] && rx_beat_ready[p]) begin
                    if (!rx_open[p]) begin
                        other_errors++;
                        $display("Beat on rx port %0d with no open frame at %0t", p, $time);
                    end else begin
                        check_beat("rx beat", rx_beat,
                                   make_beat(FRAMES[exp_rx_q[p][0]], rx_bidx[p]));
                        rx_bidx[p]++;
                        if (rx_bidx[p] == FRAMES[exp_rx_q[p][0]].beats) begin
                            void'(exp_rx_q[p].pop_front());
                            rx_open[p] = 1'b0;
                        end
                    end
                end
            end
            // Lowest offering index must own the header
            if (m_hdr_valid && m_hdr_ready) begin
                if (tx_src >= 0) begin
                    other_errors++;
                    $display("Header on m inside an open frame at %0t", $time);
                end
                tx_src = tx_hdr_valid[eth_switch_pkg::PROTO_ARP] ?
                         eth_switch_pkg::PROTO_ARP : eth_switch_pkg::PROTO_IP;
                tx_bidx = 0;
                if (exp_tx_q[tx_src].size() == 0) begin
                    other_errors++;
                    $display("Unexpected frame header on m from port %0d at %0t", tx_src, $time);
                    tx_src = -1;
                end else begin
                    check_hdr("m header", m_hdr, make_hdr(FRAMES[exp_tx_q[tx_src][0]]));
                end
            end
            if (m_beat_valid && m_beat_ready) begin
                if (tx_src < 0) begin
                    other_errors++;
                    $display("Beat on m with no open frame at %0t", $time);
                end else begin
                    check_beat("m beat", m_beat, make_beat(FRAMES[exp_tx_q[tx_src][0]], tx_bidx));
                    tx_bidx++;
                    if (tx_bidx == FRAMES[exp_tx_q[tx_src][0]].beats) begin
                        void'(exp_tx_q[tx_src].pop_front());
                        tx_src = -1;
                    end
                end
            end
        end
        // Outputs stay quiet while nothing is offered, reset included
        if (!s_hdr_valid && !s_beat_valid) begin
            check_sel("rx_hdr_valid idle", rx_hdr_valid, '0);
            check_sel("rx_beat_valid idle", rx_beat_valid, '0);
        end
        if (tx_hdr_valid == '0 && tx_beat_valid == '0) begin
            check_flag("m_hdr_valid idle", m_hdr_valid, 1'b0);
            check_flag("m_beat_valid idle", m_beat_valid, 1'b0);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d frames outstanding",
                     cycle_count, pending_frames());
            print_counts(count_missing());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int total_beats;
        int missing;
        total_beats  = 0;
        rst          = 1'b1;
        s_hdr_valid  = 1'b0;
        s_hdr        = '0;
        s_beat_valid = 1'b0;
        s_beat       = '0;
        tx_hdr_valid  = '0;
        tx_beat_valid = '0;
        for (int p = 0; p < eth_switch_pkg::PROTO_COUNT; p++) begin
            tx_hdr[p]  = '0;
            tx_beat[p] = '0;
        end
        // Expected traffic per port, unknown EtherTypes go nowhere
        for (int i = 0; i < FRAME_COUNT; i++) begin
            total_beats += FRAMES[i].beats;
            if (FRAMES[i].dir == DIR_TX) begin
                exp_tx_q[FRAMES[i].port].push_back(i);
            end else if (FRAMES[i].etype == eth_switch_pkg::ETYPE_IPV4) begin
                exp_rx_q[eth_switch_pkg::PROTO_IP].push_back(i);
            end else if (FRAMES[i].etype == eth_switch_pkg::ETYPE_ARP) begin
                exp_rx_q[eth_switch_pkg::PROTO_ARP].push_back(i);
            end
        end
        timeout_cycles = 8 * total_beats + 200;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // Both tx sources start on the same edge
        fork
            drive_rx_frames();
            drive_tx_frames(eth_switch_pkg::PROTO_ARP);
            drive_tx_frames(eth_switch_pkg::PROTO_IP);
        join
        while (pending_frames() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        missing = count_missing();
        print_counts(missing);
        if (hdr_errors + beat_errors + flag_errors + other_errors + missing == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- eth_proto_switch.f
rtl/eth_switch_pkg.sv
rtl/eth_type_demux.sv
rtl/eth_tx_arbiter.sv
rtl/eth_proto_switch.sv
bench/eth_proto_switch_tb.sv

//--- rtl/eth_proto_switch.sv
`timescale 1ns/100ps

module eth_proto_switch (
    input  logic                       clk,
    input  logic                       rst,

    // Ethernet frame input
    input  logic                       s_hdr_valid,
    output logic                       s_hdr_ready,
    input  eth_switch_pkg::eth_hdr_t   s_hdr,
    input  logic                       s_beat_valid,
    output logic                       s_beat_ready,
    input  eth_switch_pkg::eth_beat_t  s_beat,

    // Ethernet frame output
    output logic                       m_hdr_valid,
    input  logic                       m_hdr_ready,
    output eth_switch_pkg::eth_hdr_t   m_hdr,
    output logic                       m_beat_valid,
    input  logic                       m_beat_ready,
    output eth_switch_pkg::eth_beat_t  m_beat,

    // Receive side toward the protocol engines
    output eth_switch_pkg::proto_sel_t rx_hdr_valid,
    input  eth_switch_pkg::proto_sel_t rx_hdr_ready,
    output eth_switch_pkg::eth_hdr_t   rx_hdr,
    output eth_switch_pkg::proto_sel_t rx_beat_valid,
    input  eth_switch_pkg::proto_sel_t rx_beat_ready,
    output eth_switch_pkg::eth_beat_t  rx_beat,

    // Transmit side from the protocol engines
    input  eth_switch_pkg::proto_sel_t tx_hdr_valid,
    output eth_switch_pkg::proto_sel_t tx_hdr_ready,
    input  eth_switch_pkg::eth_hdr_t   tx_hdr [eth_switch_pkg::PROTO_COUNT],
    input  eth_switch_pkg::proto_sel_t tx_beat_valid,
    output eth_switch_pkg::proto_sel_t tx_beat_ready,
    input  eth_switch_pkg::eth_beat_t  tx_beat [eth_switch_pkg::PROTO_COUNT]
);

    // Receive classifier
    eth_type_demux u_demux (
        .clk           (clk),
        .rst           (rst),
        .s_hdr_valid   (s_hdr_valid),
        .s_hdr_ready   (s_hdr_ready),
        .s_hdr         (s_hdr),
        .s_beat_valid  (s_beat_valid),
        .s_beat_ready  (s_beat_ready),
        .s_beat        (s_beat),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_hdr        (rx_hdr),
        .rx_beat_valid (rx_beat_valid),
        .rx_beat_ready (rx_beat_ready),
        .rx_beat       (rx_beat)
    );

    // Transmit merge, independent of the receive path
    eth_tx_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_hdr        (tx_hdr),
        .tx_beat_valid (tx_beat_valid),
        .tx_beat_ready (tx_beat_ready),
        .tx_beat       (tx_beat),
        .m_hdr_valid   (m_hdr_valid),
        .m_hdr_ready   (m_hdr_ready),
        .m_hdr         (m_hdr),
        .m_beat_valid  (m_beat_valid),
        .m_beat_ready  (m_beat_ready),
        .m_beat        (m_beat)
    );

endmodule

//--- rtl/eth_switch_pkg.sv
package eth_switch_pkg;

    // Ethernet header fields
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ether_type_t;

    // Payload datapath, 8 bytes per beat
    localparam int DATA_BYTES = 8;
    localparam int DATA_WIDTH = 64;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [DATA_BYTES-1:0] keep_t;

    // EtherTypes recognised by the receive classifier
    localparam ether_type_t ETYPE_IPV4 = 16'h0800;
    localparam ether_type_t ETYPE_ARP  = 16'h0806;

    // Protocol engine ports, lower index wins on transmit
    localparam int PROTO_COUNT = 2;
    localparam int PROTO_ARP   = 0;
    localparam int PROTO_IP    = 1;

    // One-hot, one bit per protocol port
    typedef logic [PROTO_COUNT-1:0] proto_sel_t;

    // 112-bit Ethernet header
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        ether_type_t eth_type;
    } eth_hdr_t;

    // 74-bit payload beat
    typedef struct packed {
        data_t tdata;
        keep_t tkeep;
        logic  tlast;
        logic  tuser;
    } eth_beat_t;

    // Transmit arbiter FSM
    typedef enum logic [0:0] {
        ARB_IDLE,
        ARB_PAYLOAD
    } arb_state_e;

    // Receive demux FSM
    typedef enum logic [1:0] {
        RT_IDLE,
        RT_FORWARD,
        RT_DROP
    } route_state_e;

endpackage

//--- rtl/eth_tx_arbiter.sv
`timescale 1ns/100ps

module eth_tx_arbiter (
    input  logic                       clk,
    input  logic                       rst,

    // Protocol transmit ports
    input  eth_switch_pkg::proto_sel_t tx_hdr_valid,
    output eth_switch_pkg::proto_sel_t tx_hdr_ready,
    input  eth_switch_pkg::eth_hdr_t   tx_hdr [eth_switch_pkg::PROTO_COUNT],
    input  eth_switch_pkg::proto_sel_t tx_beat_valid,
    output eth_switch_pkg::proto_sel_t tx_beat_ready,
    input  eth_switch_pkg::eth_beat_t  tx_beat [eth_switch_pkg::PROTO_COUNT],

    // Ethernet frame output
    output logic                       m_hdr_valid,
    input  logic                       m_hdr_ready,
    output eth_switch_pkg::eth_hdr_t   m_hdr,
    output logic                       m_beat_valid,
    input  logic                       m_beat_ready,
    output eth_switch_pkg::eth_beat_t  m_beat
);

    eth_switch_pkg::arb_state_e state;
    eth_switch_pkg::proto_sel_t grant_d;
    eth_switch_pkg::proto_sel_t grant_q;
    logic                       hdr_xfer;
    logic                       last_xfer;

    // Priority encoder, lowest index wins
    always_comb begin
        grant_d = '0;
        for (int i = eth_switch_pkg::PROTO_COUNT - 1; i >= 0; i--) begin
            if (tx_hdr_valid[i]) begin
                grant_d    = '0;
                grant_d[i] = 1'b1;
            end
        end
    end

    // Header mux on the live grant
    always_comb begin
        m_hdr = tx_hdr[0];
        for (int i = 1; i < eth_switch_pkg::PROTO_COUNT; i++) begin
            if (grant_d[i]) begin
                m_hdr = tx_hdr[i];
            end
        end
    end

    // Beat mux on the held grant
    always_comb begin
        m_beat = tx_beat[0];
        for (int i = 1; i < eth_switch_pkg::PROTO_COUNT; i++) begin
            if (grant_q[i]) begin
                m_beat = tx_beat[i];
            end
        end
    end

    // Header handshake, offered only between frames
    always_comb begin
        m_hdr_valid  = 1'b0;
        tx_hdr_ready = '0;
        if (state == eth_switch_pkg::ARB_IDLE) begin
            m_hdr_valid  = tx_hdr_valid != '0;
            tx_hdr_ready = m_hdr_ready ? grant_d : '0;
        end
    end

    // Payload handshake, granted source only
    always_comb begin
        m_beat_valid  = 1'b0;
        tx_beat_ready = '0;
        if (state == eth_switch_pkg::ARB_PAYLOAD) begin
            m_beat_valid  = (tx_beat_valid & grant_q) != '0;
            tx_beat_ready = m_beat_ready ? grant_q : '0;
        end
    end

    assign hdr_xfer  = m_hdr_valid && m_hdr_ready;
    assign last_xfer = m_beat_valid && m_beat_ready && m_beat.tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= eth_switch_pkg::ARB_IDLE;
            grant_q <= '0;
        end else begin
            case (state)
                eth_switch_pkg::ARB_IDLE: begin
                    if (hdr_xfer) begin
                        grant_q <= grant_d;
                        state   <= eth_switch_pkg::ARB_PAYLOAD;
                    end
                end
                eth_switch_pkg::ARB_PAYLOAD: begin
                    // Frame ends on the tlast transfer
                    if (last_xfer) begin
                        state <= eth_switch_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= eth_switch_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    // Exactly one owner of the payload for the whole frame
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (rst)
        (state == eth_switch_pkg::ARB_PAYLOAD) |-> $onehot(grant_q)
    ) else $error("payload grant not one-hot");

    // No payload leaves without a header in front of it
    a_no_beat_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state == eth_switch_pkg::ARB_IDLE) |-> !m_beat_valid
    ) else $error("beat offered while idle");

endmodule

//--- rtl/eth_type_demux.sv
`timescale 1ns/100ps

module eth_type_demux (
    input  logic                       clk,
    input  logic                       rst,

    // Ethernet frame input
    input  logic                       s_hdr_valid,
    output logic                       s_hdr_ready,
    input  eth_switch_pkg::eth_hdr_t   s_hdr,
    input  logic                       s_beat_valid,
    output logic                       s_beat_ready,
    input  eth_switch_pkg::eth_beat_t  s_beat,

    // Protocol receive ports, header and beat buses shared
    output eth_switch_pkg::proto_sel_t rx_hdr_valid,
    input  eth_switch_pkg::proto_sel_t rx_hdr_ready,
    output eth_switch_pkg::eth_hdr_t   rx_hdr,
    output eth_switch_pkg::proto_sel_t rx_beat_valid,
    input  eth_switch_pkg::proto_sel_t rx_beat_ready,
    output eth_switch_pkg::eth_beat_t  rx_beat
);

    eth_switch_pkg::route_state_e state;
    eth_switch_pkg::proto_sel_t   hdr_sel;
    eth_switch_pkg::proto_sel_t   route_sel;
    logic                         hdr_xfer;
    logic                         last_xfer;

    // EtherType decode, all zero for an unknown type
    always_comb begin
        hdr_sel = '0;
        hdr_sel[eth_switch_pkg::PROTO_ARP] = (s_hdr.eth_type == eth_switch_pkg::ETYPE_ARP);
        hdr_sel[eth_switch_pkg::PROTO_IP]  = (s_hdr.eth_type == eth_switch_pkg::ETYPE_IPV4);
    end

    // Header stage, only open between frames
    always_comb begin
        rx_hdr_valid = '0;
        s_hdr_ready  = 1'b0;
        if (state == eth_switch_pkg::RT_IDLE) begin
            rx_hdr_valid = s_hdr_valid ? hdr_sel : '0;
            // Unknown frames are taken at once
            s_hdr_ready  = (hdr_sel == '0) || ((hdr_sel & rx_hdr_ready) != '0);
        end
    end

    // Payload stage follows the registered route
    always_comb begin
        rx_beat_valid = '0;
        s_beat_ready  = 1'b0;
        case (state)
            eth_switch_pkg::RT_FORWARD: begin
                rx_beat_valid = s_beat_valid ? route_sel : '0;
                s_beat_ready  = (route_sel & rx_beat_ready) != '0;
            end
            eth_switch_pkg::RT_DROP: begin
                // Sink the rest of the frame
                s_beat_ready = 1'b1;
            end
            default: begin
                s_beat_ready = 1'b0;
            end
        endcase
    end

    assign rx_hdr  = s_hdr;
    assign rx_beat = s_beat;

    assign hdr_xfer  = s_hdr_valid && s_hdr_ready;
    assign last_xfer = s_beat_valid && s_beat_ready && s_beat.tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= eth_switch_pkg::RT_IDLE;
            route_sel <= '0;
        end else begin
            case (state)
                eth_switch_pkg::RT_IDLE: begin
                    if (hdr_xfer) begin
                        route_sel <= hdr_sel;
                        if (hdr_sel == '0) begin
                            state <= eth_switch_pkg::RT_DROP;
                        end else begin
                            state <= eth_switch_pkg::RT_FORWARD;
                        end
                    end
                end
                eth_switch_pkg::RT_FORWARD,
                eth_switch_pkg::RT_DROP: begin
                    if (last_xfer) begin
                        state <= eth_switch_pkg::RT_IDLE;
                    end
                end
                default: begin
                    state <= eth_switch_pkg::RT_IDLE;
                end
            endcase
        end
    end

    // A frame is never split across two engines
    a_beat_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(rx_beat_valid)
    ) else $error("rx_beat_valid drives more than one port");

    // Beats only flow once a header has been routed
    a_no_beat_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state == eth_switch_pkg::RT_IDLE) |-> (rx_beat_valid == '0)
    ) else $error("beat forwarded with no routed header");

endmodule
